// ==== mc_wh_pkg.sv ====
// Manycore to wormhole adapter shared definitions
// Packet and header layouts, opcodes and per-opcode body length rules
`default_nettype none

package mc_wh_pkg;

  localparam int flit_width_c = 16;
  localparam int cord_width_c = 8;
  localparam int len_width_c  = 4;
  localparam int addr_width_c = 16;
  localparam int data_width_c = 32;

  // Manycore request opcodes
  typedef enum logic [1:0]
  {
    mc_load  = 2'd0,
    mc_store = 2'd1,
    mc_fence = 2'd2
  } mc_opcode_e;

  typedef struct packed
  {
    mc_opcode_e              op;
    logic [addr_width_c-1:0] addr;
    logic [data_width_c-1:0] data;
    logic [cord_width_c-1:0] src_cord;
  } mc_packet_s;

  // Header flit, cord is {y, x}
  typedef struct packed
  {
    logic [1:0]              op;
    logic [1:0]              reserved;
    logic [len_width_c-1:0]  len;
    logic [cord_width_c-1:0] cord;
  } wh_header_s;

  typedef logic [flit_width_c-1:0] wh_flit_t;

  localparam logic [len_width_c-1:0] body_len_store_c = 4'd4;
  localparam logic [len_width_c-1:0] body_len_load_c  = 4'd2;
  localparam logic [len_width_c-1:0] body_len_fence_c = 4'd1;

  // Body flit slots in their wire order
  typedef enum logic [1:0]
  {
    body_addr    = 2'd0,
    body_data_lo = 2'd1,
    body_data_hi = 2'd2,
    body_src     = 2'd3
  } body_field_e;

  // Number of body flits behind the header
  function automatic logic [len_width_c-1:0] body_len(mc_opcode_e op);
    case (op)
      mc_store: body_len = body_len_store_c;
      mc_load:  body_len = body_len_load_c;
      default:  body_len = body_len_fence_c;
    endcase
  endfunction

  // Which field the idx-th body flit of an opcode carries
  function automatic body_field_e body_field(mc_opcode_e op, logic [len_width_c-1:0] idx);
    case (op)
      mc_store: body_field = body_field_e'(idx[1:0]);
      mc_load:  body_field = (idx == '0) ? body_addr : body_src;
      default:  body_field = body_src;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== wh_flit_serializer.sv ====
// Wormhole flit serializer
// Splits one manycore packet into a header flit and its body flits,
// skipping the fields that the opcode does not send
`default_nettype none

module wh_flit_serializer
(
  input  logic                               mc_clk_i,
  input  logic                               rst_i,
  input  mc_wh_pkg::mc_packet_s              pkt_i,
  input  logic                               pkt_v_i,
  output logic                               pkt_ready_o,
  input  logic [mc_wh_pkg::cord_width_c-1:0] dest_cord_i,
  output mc_wh_pkg::wh_flit_t                flit_o,
  output logic                               flit_v_o,
  input  logic                               flit_ready_i
);
  import mc_wh_pkg::*;

  typedef enum logic [1:0]
  {
    ser_idle,
    ser_header,
    ser_body
  } ser_state_e;

  ser_state_e              state_r;
  mc_packet_s              pkt_r;
  logic [cord_width_c-1:0] cord_r;
  logic [len_width_c-1:0]  idx_r;
  logic [len_width_c-1:0]  len;
  wh_header_s              header;
  wh_flit_t                body;
  logic                    pkt_take;
  logic                    flit_done;
  logic                    last_body;

  assign pkt_ready_o = (state_r == ser_idle);
  assign flit_v_o    = (state_r != ser_idle);
  assign pkt_take    = pkt_v_i & pkt_ready_o;
  assign flit_done   = flit_v_o & flit_ready_i;
  assign len         = body_len(pkt_r.op);
  assign last_body   = (idx_r == len - 1'b1);

  always_comb
  begin
    header      = '0;
    header.op   = pkt_r.op;
    header.len  = len;
    header.cord = cord_r;
  end

  // Body flit mux, indexed through the opcode's field order
  always_comb
  begin
    case (body_field(pkt_r.op, idx_r))
      body_addr:    body = pkt_r.addr;
      body_data_lo: body = pkt_r.data[flit_width_c-1:0];
      body_data_hi: body = pkt_r.data[data_width_c-1:flit_width_c];
      default:      body = {{(flit_width_c-cord_width_c){1'b0}}, pkt_r.src_cord};
    endcase
  end

  assign flit_o = (state_r == ser_header) ? wh_flit_t'(header) : body;

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= ser_idle;
      idx_r   <= '0;
    end
    else
    begin
      case (state_r)
        ser_idle:
          if (pkt_take)
          begin
            state_r <= ser_header;
          end
        ser_header:
          if (flit_done)
          begin
            state_r <= ser_body;
            idx_r   <= '0;
          end
        ser_body:
          if (flit_done)
          begin
            if (last_body)
            begin
              state_r <= ser_idle;
              idx_r   <= '0;
            end
            else
            begin
              idx_r <= idx_r + 1'b1;
            end
          end
        default:
          state_r <= ser_idle;
      endcase
    end
  end

  // Packet and destination are held for the whole burst
  always_ff @(posedge mc_clk_i)
  begin
    if (pkt_take)
    begin
      pkt_r  <= pkt_i;
      cord_r <= dest_cord_i;
    end
  end

endmodule

`default_nettype wire

// ==== wh_flit_fifo.sv ====
// Valid/ready flit FIFO
// Circular buffer with wrap-bit pointers, output read straight from storage
`default_nettype none

module wh_flit_fifo
#(
  parameter int fifo_depth_p = 4
)
(
  input  logic                mc_clk_i,
  input  logic                rst_i,
  input  mc_wh_pkg::wh_flit_t wr_flit_i,
  input  logic                wr_v_i,
  output logic                wr_ready_o,
  output mc_wh_pkg::wh_flit_t rd_flit_o,
  output logic                rd_v_o,
  input  logic                rd_ready_i
);
  import mc_wh_pkg::*;

  localparam int addr_width_lp = $clog2(fifo_depth_p);

  wh_flit_t               mem [fifo_depth_p];
  logic [addr_width_lp:0] wr_ptr_r;
  logic [addr_width_lp:0] rd_ptr_r;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   rd_en;

  // Same index, wrap bits differ when full
  assign empty = (wr_ptr_r == rd_ptr_r);
  assign full  = (wr_ptr_r[addr_width_lp] != rd_ptr_r[addr_width_lp])
              && (wr_ptr_r[addr_width_lp-1:0] == rd_ptr_r[addr_width_lp-1:0]);

  assign wr_ready_o = ~full;
  assign rd_v_o     = ~empty;
  assign wr_en      = wr_v_i & ~full;
  assign rd_en      = rd_ready_i & ~empty;
  assign rd_flit_o  = mem[rd_ptr_r[addr_width_lp-1:0]];

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (wr_en)
    begin
      mem[wr_ptr_r[addr_width_lp-1:0]] <= wr_flit_i;
    end
  end

endmodule

`default_nettype wire

// ==== wh_flit_deserializer.sv ====
// Wormhole flit deserializer
// Collects a header and its body flits and rebuilds the manycore packet,
// unsent fields come back as zero
`default_nettype none

module wh_flit_deserializer
(
  input  logic                  mc_clk_i,
  input  logic                  rst_i,
  input  mc_wh_pkg::wh_flit_t   flit_i,
  input  logic                  flit_v_i,
  output logic                  flit_ready_o,
  output mc_wh_pkg::mc_packet_s pkt_o,
  output logic                  pkt_v_o,
  input  logic                  pkt_ready_i
);
  import mc_wh_pkg::*;

  typedef enum logic [1:0]
  {
    des_header,
    des_body,
    des_hold
  } des_state_e;

  des_state_e             state_r;
  mc_packet_s             pkt_r;
  logic [len_width_c-1:0] len_r;
  logic [len_width_c-1:0] idx_r;
  wh_header_s             header;
  logic                   flit_take;
  logic                   last_body;

  assign header       = flit_i;
  assign flit_ready_o = (state_r != des_hold);
  assign flit_take    = flit_v_i & flit_ready_o;
  assign last_body    = (idx_r == len_r - 1'b1);
  assign pkt_v_o      = (state_r == des_hold);
  assign pkt_o        = pkt_r;

  always_ff @(posedge mc_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= des_header;
      len_r   <= '0;
      idx_r   <= '0;
    end
    else
    begin
      case (state_r)
        des_header:
          if (flit_take)
          begin
            state_r <= des_body;
            len_r   <= header.len;
            idx_r   <= '0;
          end
        des_body:
          if (flit_take)
          begin
            if (last_body)
            begin
              state_r <= des_hold;
            end
            else
            begin
              idx_r <= idx_r + 1'b1;
            end
          end
        des_hold:
          // Finished packet waits here for the manycore side
          if (pkt_ready_i)
          begin
            state_r <= des_header;
          end
        default:
          state_r <= des_header;
      endcase
    end
  end

  // Header clears the packet, body flits land in their fields
  always_ff @(posedge mc_clk_i)
  begin
    if (flit_take && (state_r == des_header))
    begin
      pkt_r    <= '0;
      pkt_r.op <= mc_opcode_e'(header.op);
    end
    else if (flit_take && (state_r == des_body))
    begin
      case (body_field(pkt_r.op, idx_r))
        body_addr:    pkt_r.addr <= flit_i;
        body_data_lo: pkt_r.data[flit_width_c-1:0] <= flit_i;
        body_data_hi: pkt_r.data[data_width_c-1:flit_width_c] <= flit_i;
        default:      pkt_r.src_cord <= flit_i[cord_width_c-1:0];
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mc_wh_adapter_top.sv ====
// Manycore link to wormhole adapter
// Outbound path serializes packets into a flit FIFO, inbound path
// buffers flits and rebuilds packets
`default_nettype none

module mc_wh_adapter_top
#(
  parameter int fifo_depth_p = 4
)
(
  input  logic                               mc_clk_i,
  input  logic                               rst_i,
  // Manycore send side
  input  mc_wh_pkg::mc_packet_s              mc_pkt_i,
  input  logic                               mc_pkt_v_i,
  output logic                               mc_pkt_ready_o,
  // Manycore receive side
  output mc_wh_pkg::mc_packet_s              mc_pkt_o,
  output logic                               mc_pkt_v_o,
  input  logic                               mc_pkt_ready_i,
  // Stable before reset is released
  input  logic [mc_wh_pkg::cord_width_c-1:0] mc_dest_cord_i,
  // Wormhole link
  output mc_wh_pkg::wh_flit_t                wh_flit_o,
  output logic                               wh_v_o,
  input  logic                               wh_ready_i,
  input  mc_wh_pkg::wh_flit_t                wh_flit_i,
  input  logic                               wh_v_i,
  output logic                               wh_ready_o
);
  import mc_wh_pkg::*;

  wh_flit_t ser_flit;
  logic     ser_v;
  logic     ser_ready;
  wh_flit_t des_flit;
  logic     des_v;
  logic     des_ready;

  // Outbound path
  wh_flit_serializer ser
  (
    .mc_clk_i     (mc_clk_i),
    .rst_i        (rst_i),
    .pkt_i        (mc_pkt_i),
    .pkt_v_i      (mc_pkt_v_i),
    .pkt_ready_o  (mc_pkt_ready_o),
    .dest_cord_i  (mc_dest_cord_i),
    .flit_o       (ser_flit),
    .flit_v_o     (ser_v),
    .flit_ready_i (ser_ready)
  );

  wh_flit_fifo #(.fifo_depth_p(fifo_depth_p)) out_fifo
  (
    .mc_clk_i   (mc_clk_i),
    .rst_i      (rst_i),
    .wr_flit_i  (ser_flit),
    .wr_v_i     (ser_v),
    .wr_ready_o (ser_ready),
    .rd_flit_o  (wh_flit_o),
    .rd_v_o     (wh_v_o),
    .rd_ready_i (wh_ready_i)
  );

  // Inbound path
  wh_flit_fifo #(.fifo_depth_p(fifo_depth_p)) in_fifo
  (
    .mc_clk_i   (mc_clk_i),
    .rst_i      (rst_i),
    .wr_flit_i  (wh_flit_i),
    .wr_v_i     (wh_v_i),
    .wr_ready_o (wh_ready_o),
    .rd_flit_o  (des_flit),
    .rd_v_o     (des_v),
    .rd_ready_i (des_ready)
  );

  wh_flit_deserializer des
  (
    .mc_clk_i     (mc_clk_i),
    .rst_i        (rst_i),
    .flit_i       (des_flit),
    .flit_v_i     (des_v),
    .flit_ready_o (des_ready),
    .pkt_o        (mc_pkt_o),
    .pkt_v_o      (mc_pkt_v_o),
    .pkt_ready_i  (mc_pkt_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_mc_wh_adapter.sv ====
// Testbench for the manycore to wormhole adapter
// Sends packets from a pattern file around a wormhole loopback and checks
// the flit stream and the rebuilt packets against the packet rules
`default_nettype none

module tb_mc_wh_adapter;
  import mc_wh_pkg::*;

  localparam int num_patterns_lp  = 16;
  localparam int fields_lp        = 5;
  localparam int fill_patterns_lp = 4;
  // Two full passes plus both FIFO fill tests
  localparam int cycle_limit_lp   = 40 * (2 * num_patterns_lp + fill_patterns_lp) + 100;

  logic                    mc_clk_i;
  logic                    rst_i;
  mc_packet_s              mc_pkt_i;
  logic                    mc_pkt_v_i;
  logic                    mc_pkt_ready_o;
  mc_packet_s              mc_pkt_o;
  logic                    mc_pkt_v_o;
  logic                    mc_pkt_ready_i;
  logic [cord_width_c-1:0] mc_dest_cord_i;
  wh_flit_t                wh_flit_o;
  logic                    wh_v_o;
  logic                    wh_ready_i;
  wh_flit_t                wh_flit_i;
  logic                    wh_v_i;
  logic                    wh_ready_o;

  logic        link_stall;
  logic        fill_hold;
  logic        pkt_stall;
  logic        pkt_hold;
  logic        stall_en;
  logic        link_open;
  logic [31:0] pat_mem [num_patterns_lp*fields_lp];
  wh_flit_t    exp_flit_q [$];
  mc_packet_s  exp_pkt_q [$];
  wh_flit_t    exp_flit;
  mc_packet_s  exp_pkt;
  logic        wh_stalled_r;
  wh_flit_t    wh_held_r;
  logic        pkt_stalled_r;
  mc_packet_s  pkt_held_r;
  int          error_count;
  int          test_num;
  int          test_start_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;
  int unsigned seed_word;

  mc_wh_adapter_top #(.fifo_depth_p(4)) mc_wh_adapter_top_i
  (
    .mc_clk_i       (mc_clk_i),
    .rst_i          (rst_i),
    .mc_pkt_i       (mc_pkt_i),
    .mc_pkt_v_i     (mc_pkt_v_i),
    .mc_pkt_ready_o (mc_pkt_ready_o),
    .mc_pkt_o       (mc_pkt_o),
    .mc_pkt_v_o     (mc_pkt_v_o),
    .mc_pkt_ready_i (mc_pkt_ready_i),
    .mc_dest_cord_i (mc_dest_cord_i),
    .wh_flit_o      (wh_flit_o),
    .wh_v_o         (wh_v_o),
    .wh_ready_i     (wh_ready_i),
    .wh_flit_i      (wh_flit_i),
    .wh_v_i         (wh_v_i),
    .wh_ready_o     (wh_ready_o)
  );

  // Loopback stage, one gate withholds both sides so no flit is dropped
  assign link_open      = ~link_stall & ~fill_hold;
  assign wh_flit_i      = wh_flit_o;
  assign wh_v_i         = wh_v_o & link_open;
  assign wh_ready_i     = wh_ready_o & link_open;
  assign mc_pkt_ready_i = ~pkt_stall & ~pkt_hold;

  initial mc_clk_i = 1'b0;
  always #2 mc_clk_i = ~mc_clk_i;

  always @(posedge mc_clk_i)
  begin
    #1;
    link_stall = stall_en && (($urandom % 4) == 0);
    pkt_stall  = stall_en && (($urandom % 3) == 0);
  end

  always @(posedge mc_clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit_lp)
    begin
      $display("Run timed out after %0d cycles, %0d packets never came back",
               cycle_count, exp_pkt_q.size());
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic mc_packet_s pattern_packet(input int idx);
    mc_packet_s pkt;
    pkt.op       = mc_opcode_e'(pat_mem[idx*fields_lp][1:0]);
    pkt.addr     = pat_mem[idx*fields_lp+1][15:0];
    pkt.data     = pat_mem[idx*fields_lp+2];
    pkt.src_cord = pat_mem[idx*fields_lp+3][7:0];
    return pkt;
  endfunction

  function automatic logic [7:0] pattern_dest(input int idx);
    return pat_mem[idx*fields_lp+4][7:0];
  endfunction

  // Header, then addr, data low, data high, padded src as the opcode allows
  task automatic queue_expected(input mc_packet_s pkt, input logic [7:0] dest);
    mc_packet_s want;
    wh_flit_t   src_flit;
    logic [3:0] len;
    want          = '0;
    want.op       = pkt.op;
    want.src_cord = pkt.src_cord;
    src_flit      = {8'h00, pkt.src_cord};
    len           = (pkt.op == mc_store) ? 4'd4 : (pkt.op == mc_load) ? 4'd2 : 4'd1;
    exp_flit_q.push_back({pkt.op, 2'b00, len, dest});
    if (pkt.op == mc_store)
    begin
      exp_flit_q.push_back(pkt.addr);
      exp_flit_q.push_back(pkt.data[15:0]);
      exp_flit_q.push_back(pkt.data[31:16]);
      want.addr = pkt.addr;
      want.data = pkt.data;
    end
    else if (pkt.op == mc_load)
    begin
      exp_flit_q.push_back(pkt.addr);
      want.addr = pkt.addr;
    end
    exp_flit_q.push_back(src_flit);
    exp_pkt_q.push_back(want);
  endtask

  // Offers one pattern and returns after the accepting edge
  task automatic send_packet(input int idx);
    queue_expected(pattern_packet(idx), pattern_dest(idx));
    mc_pkt_i       = pattern_packet(idx);
    mc_dest_cord_i = pattern_dest(idx);
    mc_pkt_v_i     = 1'b1;
    @(negedge mc_clk_i);
    while (!mc_pkt_ready_o)
      @(negedge mc_clk_i);
    @(posedge mc_clk_i);
    #1;
    mc_pkt_v_i = 1'b0;
  endtask

  task automatic wait_drained();
    while ((exp_pkt_q.size() != 0) || (exp_flit_q.size() != 0))
      @(posedge mc_clk_i);
    @(posedge mc_clk_i);
    #1;
  endtask

  task automatic start_test();
    test_num          = test_num + 1;
    test_start_errors = error_count;
  endtask

  task automatic report_test(input string name);
    if (error_count == test_start_errors)
    begin
      tests_passed = tests_passed + 1;
      $display("Test %0d (%s): passed", test_num, name);
    end
    else
    begin
      tests_failed = tests_failed + 1;
      $display("Test %0d (%s): failed with %0d errors", test_num, name,
               error_count - test_start_errors);
    end
  endtask

  // Wormhole link monitor, flit order and hold while stalled
  always @(negedge mc_clk_i)
  begin
    if (!rst_i)
    begin
      if (wh_stalled_r)
      begin
        assert (wh_v_o && (wh_flit_o == wh_held_r))
        else
        begin
          $display("error %0t: stalled flit changed from %h to %h", $time, wh_held_r, wh_flit_o);
          error_count = error_count + 1;
        end
      end
      if (wh_v_o && wh_ready_i)
      begin
        assert (exp_flit_q.size() != 0)
        else
        begin
          $display("Flit %h left the adapter when no flit was due", wh_flit_o);
          error_count = error_count + 1;
        end
        if (exp_flit_q.size() != 0)
        begin
          exp_flit = exp_flit_q.pop_front();
          assert (wh_flit_o == exp_flit)
          else
          begin
            $display("error %0t: flit %h, expected %h", $time, wh_flit_o, exp_flit);
            error_count = error_count + 1;
          end
        end
      end
      wh_stalled_r = wh_v_o && !wh_ready_i;
      wh_held_r    = wh_flit_o;
    end
  end

  // Manycore receive monitor
  always @(negedge mc_clk_i)
  begin
    if (!rst_i)
    begin
      if (pkt_stalled_r)
      begin
        assert (mc_pkt_v_o && (mc_pkt_o == pkt_held_r))
        else
        begin
          $display("error %0t: held packet changed to %h", $time, mc_pkt_o);
          error_count = error_count + 1;
        end
      end
      if (mc_pkt_v_o && mc_pkt_ready_i)
      begin
        assert (exp_pkt_q.size() != 0)
        else
        begin
          $display("Packet %h came back when no packet was due", mc_pkt_o);
          error_count = error_count + 1;
        end
        if (exp_pkt_q.size() != 0)
        begin
          exp_pkt = exp_pkt_q.pop_front();
          assert (mc_pkt_o == exp_pkt)
          else
          begin
            $display("error %0t: packet %h, expected %h", $time, mc_pkt_o, exp_pkt);
            error_count = error_count + 1;
          end
        end
      end
      pkt_stalled_r = mc_pkt_v_o && !mc_pkt_ready_i;
      pkt_held_r    = mc_pkt_o;
    end
  end

  initial
  begin
    seed_word         = $urandom(88622);
    rst_i             = 1'b1;
    mc_pkt_i          = '0;
    mc_pkt_v_i        = 1'b0;
    mc_dest_cord_i    = '0;
    link_stall        = 1'b0;
    pkt_stall         = 1'b0;
    pkt_hold          = 1'b0;
    fill_hold         = 1'b0;
    stall_en          = 1'b0;
    wh_stalled_r      = 1'b0;
    pkt_stalled_r     = 1'b0;
    error_count       = 0;
    test_num          = 0;
    test_start_errors = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    cycle_count       = 0;
    $readmemh("mc_wh_patterns.hex", pat_mem);
    foreach (pat_mem[i])
      assert (^pat_mem[i] !== 1'bx)
      else
      begin
        $display("Pattern file is missing or short, word %0d was not loaded", i);
        error_count = error_count + 1;
      end
    mc_dest_cord_i = pattern_dest(0);
    repeat (3) @(posedge mc_clk_i);
    #1;
    rst_i = 1'b0;

    start_test();
    @(negedge mc_clk_i);
    assert (!mc_pkt_v_o && !wh_v_o && mc_pkt_ready_o)
    else
    begin
      $display("error %0t: after reset pkt_v %b wh_v %b ready %b", $time,
               mc_pkt_v_o, wh_v_o, mc_pkt_ready_o);
      error_count = error_count + 1;
    end
    @(posedge mc_clk_i);
    #1;
    report_test("reset state");

    start_test();
    for (int i = 0; i < num_patterns_lp; i++)
      send_packet(i);
    wait_drained();
    report_test("flit format and loopback");

    start_test();
    stall_en = 1'b1;
    for (int i = 0; i < num_patterns_lp; i++)
      send_packet(i);
    wait_drained();
    stall_en = 1'b0;
    report_test("random back-pressure");

    // Store of five flits overfills the outbound FIFO
    start_test();
    fill_hold = 1'b1;
    send_packet(0);
    repeat (12) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    assert (wh_v_o && !mc_pkt_ready_o && (wh_flit_o == exp_flit_q[0]))
    else
    begin
      $display("error %0t: full FIFO shows v %b flit %h, ready %b", $time,
               wh_v_o, wh_flit_o, mc_pkt_ready_o);
      error_count = error_count + 1;
    end
    @(posedge mc_clk_i);
    #1;
    fill_hold = 1'b0;
    send_packet(1);
    wait_drained();
    report_test("outbound FIFO fill");

    // Two stores behind a held packet fill the inbound FIFO
    start_test();
    pkt_hold = 1'b1;
    send_packet(0);
    send_packet(3);
    repeat (16) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    assert (mc_pkt_v_o && !wh_ready_o && wh_v_o)
    else
    begin
      $display("error %0t: inbound fill shows pkt_v %b wh_ready %b wh_v %b", $time,
               mc_pkt_v_o, wh_ready_o, wh_v_o);
      error_count = error_count + 1;
    end
    @(posedge mc_clk_i);
    #1;
    pkt_hold = 1'b0;
    wait_drained();
    report_test("inbound FIFO fill");

    $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", test_num,
             tests_passed, tests_failed, error_count);
    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mc_wh_patterns.hex ====
// Columns: op addr data src_cord dest_cord, one packet per line, all hex
// op 0 is load, 1 is store, 2 is fence
1 a0c4 deadbeef 21 35
0 1f00 0badf00d 13 42
2 7777 12345678 44 01
1 0004 cafe0001 00 ff
1 ffff ffffffff ff 10
0 0000 55aa55aa 32 23
2 0000 00000000 07 70
1 1234 89abcdef 5a a5
0 beef 31415926 66 0c
0 0010 27182818 0f f0
2 c0de 0f0f0f0f 81 18
1 8000 80000001 12 21
1 0102 03040506 99 3c
0 abcd ef012345 4e e4
2 5555 aaaaaaaa 3b b3
1 0a0b 0c0d0e0f c3 3c

// ==== build.f ====
mc_wh_pkg.sv
wh_flit_serializer.sv
wh_flit_fifo.sv
wh_flit_deserializer.sv
mc_wh_adapter_top.sv
tb_mc_wh_adapter.sv

// ==== Bender.yml ====
package:
  name: mc_wh_adapter

sources:
  - files:
      - mc_wh_pkg.sv
      - wh_flit_serializer.sv
      - wh_flit_fifo.sv
      - wh_flit_deserializer.sv
      - mc_wh_adapter_top.sv
  - target: test
    files:
      - tb_mc_wh_adapter.sv
